/* all.f */
+incdir+source
source/dnc_pkg.sv
source/dnc_operand_loader.sv
source/dnc_operand_memory.sv
source/dnc_mac_unit.sv
source/dnc_backward_weighting.sv
source/dnc_backward_top.sv
verification/tb_dnc_backward.sv

/* run.sh */
#!/usr/bin/env bash
# Build with Verilator and run; exit status follows the simulation result
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_dnc_backward -f all.f --Mdir obj_dir -o sim_dnc \
  && ./obj_dir/sim_dnc \
  || { echo "build or simulation did not complete cleanly"; exit 1; }

/* verification/tb_dnc_backward.sv */
// Three batches (random, all ones, all zeros); checks stop the run at the first mismatch
`timescale 1ns/1ps
`include "dnc_defs.svh"

module tb_dnc_backward import dnc_pkg::*; ();

  localparam int LINK_WORDS = `DNC_N * `DNC_N;
  localparam int WGT_WORDS  = `DNC_R * `DNC_N;
  localparam int BEATS      = `DNC_R * `DNC_N;
  localparam int BATCHES    = 3;
  localparam int ONES_BATCH = 1;
  localparam int ZERO_BATCH = 2;
  // Longest out_ack hold after out_req falls, about twice an element's compute time
  localparam int ACK_HOLD_MAX = 2 * (`DNC_N + 3);
  // Loads take 4 cycles each, a result about 12 plus the ack hold, doubled for margin
  localparam int WATCHDOG_CYCLES =
    2 * BATCHES * ((LINK_WORDS + WGT_WORDS) * 4 + BEATS * (12 + ACK_HOLD_MAX));

  logic         CLK;
  logic         RST;
  logic         in_req;
  fixed_t       in_word;
  logic         in_ack;
  logic         out_req;
  logic         out_ack;
  result_beat_t out_beat;
  logic         busy;

  // Reference copies of L and w for the batch in flight
  fixed_t link_mdl [LINK_WORDS];
  fixed_t wgt_mdl  [WGT_WORDS];

  logic out_req_d = 1'b0;
  logic busy_d = 1'b0;
  int   beats_in_batch = 0;
  int   batches_done = 0;

  dnc_backward_top dut_i (
    .CLK      (CLK),
    .RST      (RST),
    .in_req   (in_req),
    .in_word  (in_word),
    .in_ack   (in_ack),
    .out_req  (out_req),
    .out_ack  (out_ack),
    .out_beat (out_beat),
    .busy     (busy)
  );

  //////////////////////////////////////////////////
  // Reference model and helpers
  //////////////////////////////////////////////////

  // b(i,j) = sum over g of L(g,j) * w(i,g), floor >> 15, clamp
  function automatic fixed_t expected_value(input int i, input int j);
    logic [63:0] total;
    total = '0;
    for (int g = 0; g < `DNC_N; g++) begin
      total = total + 64'(link_mdl[g * `DNC_N + j]) * 64'(wgt_mdl[i * `DNC_N + g]);
    end
    total = total >> `DNC_FRAC_W;
    return (total > 64'hFFFF) ? 16'hFFFF : total[15:0];
  endfunction

  function automatic fixed_t next_operand(input int batch);
    if (batch == ONES_BATCH) begin
      return 16'hFFFF;
    end else if (batch == ZERO_BATCH) begin
      return 16'h0000;
    end
    // Up to 1.0, so some sums clamp and some do not
    return fixed_t'($urandom_range(32'h7FFF));
  endfunction

  task automatic fail_run(input string what);
    $display("Error at %0t ns: %s", $time, what);
    $display("Test failed");
    $fatal(1, "%s", what);
  endtask

  // Full four-phase cycle for one word, model updated once acked
  task automatic send_word(input fixed_t value, input int pos);
    in_word <= value;
    in_req  <= 1'b1;
    do begin
      @(posedge CLK);
    end while (!in_ack);
    in_req <= 1'b0;
    if (pos < LINK_WORDS) begin
      link_mdl[pos] = value;
    end else begin
      wgt_mdl[pos - LINK_WORDS] = value;
    end
    do begin
      @(posedge CLK);
    end while (in_ack);
  endtask

  //////////////////////////////////////////////////
  // Clock, stimulus, ack responder, watchdog
  //////////////////////////////////////////////////

  initial begin
    CLK = 1'b0;
    forever #50 CLK = ~CLK;
  end

  initial begin
    void'($urandom(32'h7b04));
    RST     = 1'b1;
    in_req  = 1'b0;
    in_word = '0;
    repeat (2) @(posedge CLK);
    RST <= 1'b0;
    // Next batch is offered while the previous one still computes
    for (int b = 0; b < BATCHES; b++) begin
      for (int k = 0; k < LINK_WORDS + WGT_WORDS; k++) begin
        send_word(next_operand(b), k);
      end
    end
    while (batches_done < BATCHES) begin
      @(posedge CLK);
    end
    repeat (2) @(posedge CLK);
    $display("Test passed");
    $finish;
  end

  // Random 0..3 cycle delay before each ack, random hold after req falls
  initial begin
    int delay;
    int hold;
    out_ack = 1'b0;
    forever begin
      @(posedge CLK);
      if (out_req && !out_ack) begin
        delay = $urandom_range(3);
        repeat (delay) @(posedge CLK);
        out_ack <= 1'b1;
        do begin
          @(posedge CLK);
        end while (out_req);
        // Long holds reach past the next element's compute time
        hold = $urandom_range(ACK_HOLD_MAX);
        repeat (hold) @(posedge CLK);
        out_ack <= 1'b0;
      end
    end
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge CLK);
    $display("Test failed");
    $fatal(1, "The run timed out before all batches finished");
  end

  //////////////////////////////////////////////////
  // Beat tracking and checks
  //////////////////////////////////////////////////

  always_ff @(posedge CLK) begin
    out_req_d <= out_req;
    busy_d    <= busy;
    if (out_req && !out_req_d) begin
      beats_in_batch <= beats_in_batch + 1;
    end
    if (!busy && busy_d) begin
      beats_in_batch <= 0;
      batches_done   <= batches_done + 1;
    end
  end

  a_reset_quiet: assert property (@(posedge CLK)
    $fell(RST) |-> (!in_ack && !out_req && !busy))
    else fail_run("in_ack, out_req or busy high right after reset");

  a_value: assert property (@(posedge CLK) disable iff (RST)
    $rose(out_req) |-> (out_beat.value == expected_value(out_beat.head, out_beat.loc)))
    else fail_run($sformatf("beat (%0d,%0d) is %h, expected %h", out_beat.head, out_beat.loc,
                            out_beat.value, expected_value(out_beat.head, out_beat.loc)));

  // i outer, j inner
  a_order: assert property (@(posedge CLK) disable iff (RST)
    $rose(out_req) |-> (out_beat.head == index_t'(beats_in_batch / `DNC_N) &&
                        out_beat.loc == index_t'(beats_in_batch % `DNC_N)))
    else fail_run($sformatf("beat %0d out of order", beats_in_batch));

  a_count: assert property (@(posedge CLK) disable iff (RST)
    $fell(busy) |-> (beats_in_batch == BEATS))
    else fail_run($sformatf("busy fell after %0d beats", beats_in_batch));

  a_saturate: assert property (@(posedge CLK) disable iff (RST)
    ($rose(out_req) && batches_done == ONES_BATCH) |-> (out_beat.value == 16'hFFFF))
    else fail_run("all-ones batch did not saturate");

  a_zero: assert property (@(posedge CLK) disable iff (RST)
    ($rose(out_req) && batches_done == ZERO_BATCH) |-> (out_beat.value == 16'h0000))
    else fail_run("all-zero batch gave a nonzero beat");

  a_beat_hold: assert property (@(posedge CLK) disable iff (RST)
    (out_req && $past(out_req)) |-> $stable(out_beat))
    else fail_run("out_beat changed during the handshake");

  a_req_after_ack: assert property (@(posedge CLK) disable iff (RST)
    $rose(out_req) |-> !out_ack)
    else fail_run("out_req rose again before out_ack fell");

  // in_req is already high for the next batch here
  a_hold_off: assert property (@(posedge CLK) disable iff (RST)
    busy |-> !$rose(in_ack))
    else fail_run("a word was acked while a batch was being computed");

endmodule

/* source/dnc_backward_top.sv */
// Backward weighting b = L^T w for fixed N and R; one batch of N*N + R*N words in, R*N beats out
`timescale 1ns/1ps
`include "dnc_defs.svh"

module dnc_backward_top import dnc_pkg::*; (
  input  logic         CLK,
  input  logic         RST,
  input  logic         in_req,
  input  fixed_t       in_word,
  output logic         in_ack,
  output logic         out_req,
  input  logic         out_ack,
  output result_beat_t out_beat,
  output logic         busy
);

  //////////////////////////////////////////////////
  // Internal nets
  //////////////////////////////////////////////////

  // Loader to memory and controller
  mem_wr_t mem_wr;
  logic    batch_full;
  logic    batch_release;

  // Controller to memory and MAC
  mem_rd_t mem_rd;
  logic    mac_first;
  logic    mac_last;

  // Memory and MAC datapath
  fixed_t  link_rd;
  fixed_t  weight_rd;
  fixed_t  mac_result;
  logic    mac_valid;

  //////////////////////////////////////////////////
  // Instances
  //////////////////////////////////////////////////

  dnc_operand_loader loader_i (
    .CLK           (CLK),
    .RST           (RST),
    .in_req        (in_req),
    .in_word       (in_word),
    .in_ack        (in_ack),
    .mem_wr        (mem_wr),
    .batch_full    (batch_full),
    .batch_release (batch_release)
  );

  // Transposed link reads
  dnc_operand_memory memory_i (
    .CLK       (CLK),
    .RST       (RST),
    .mem_wr    (mem_wr),
    .mem_rd    (mem_rd),
    .link_rd   (link_rd),
    .weight_rd (weight_rd)
  );

  dnc_mac_unit mac_i (
    .CLK        (CLK),
    .RST        (RST),
    .link_rd    (link_rd),
    .weight_rd  (weight_rd),
    .mac_first  (mac_first),
    .mac_last   (mac_last),
    .mac_result (mac_result),
    .mac_valid  (mac_valid)
  );

  dnc_backward_weighting ctrl_i (
    .CLK           (CLK),
    .RST           (RST),
    .batch_full    (batch_full),
    .batch_release (batch_release),
    .mem_rd        (mem_rd),
    .mac_first     (mac_first),
    .mac_last      (mac_last),
    .mac_result    (mac_result),
    .mac_valid     (mac_valid),
    .out_req       (out_req),
    .out_ack       (out_ack),
    .out_beat      (out_beat),
    .busy          (busy)
  );

endmodule

/* source/dnc_backward_weighting.sv */
// Walks i, j, g over one loaded batch; one result element in flight at a time, four-phase output
`timescale 1ns/1ps
`include "dnc_defs.svh"

module dnc_backward_weighting import dnc_pkg::*; (
  input  logic         CLK,
  input  logic         RST,
  input  logic         batch_full,
  output logic         batch_release,
  output mem_rd_t      mem_rd,
  output logic         mac_first,
  output logic         mac_last,
  input  fixed_t       mac_result,
  input  logic         mac_valid,
  output logic         out_req,
  input  logic         out_ack,
  output result_beat_t out_beat,
  output logic         busy
);

  //////////////////////////////////////////////////
  // State and loop counters
  //////////////////////////////////////////////////

  ctrl_state_t state;
  index_t      head_i;
  index_t      loc_j;
  index_t      sum_g;
  logic        rd_first;
  logic        rd_last;
  logic        last_g;
  logic        last_elem;

  assign last_g    = (sum_g == index_t'(`DNC_N - 1));
  assign last_elem = (head_i == index_t'(`DNC_R - 1)) && (loc_j == index_t'(`DNC_N - 1));

  // Read address straight from the counters
  assign mem_rd = '{i: head_i, j: loc_j, g: sum_g};

  // Sum boundaries at read time
  assign rd_first = (state == st_accumulate) && (sum_g == '0);
  assign rd_last  = (state == st_accumulate) && last_g;

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state         <= st_idle;
      head_i        <= '0;
      loc_j         <= '0;
      sum_g         <= '0;
      out_req       <= 1'b0;
      busy          <= 1'b0;
      batch_release <= 1'b0;
      mac_first     <= 1'b0;
      mac_last      <= 1'b0;
    end else begin
      // Memory read latency is one cycle
      mac_first     <= rd_first;
      mac_last      <= rd_last;
      batch_release <= 1'b0;
      case (state)
        st_idle: begin
          // Release pulse still visible, full flag not yet cleared
          if (batch_full && !batch_release) begin
            state  <= st_accumulate;
            busy   <= 1'b1;
            head_i <= '0;
            loc_j  <= '0;
            sum_g  <= '0;
          end
        end
        st_accumulate: begin
          // One read per cycle along g
          if (last_g) begin
            sum_g <= '0;
            state <= st_drain;
          end else begin
            sum_g <= sum_g + 1'b1;
          end
        end
        st_drain: begin
          // Wait for the MAC pipeline
          if (mac_valid) begin
            out_req <= 1'b1;
            state   <= st_offer;
          end
        end
        st_offer: begin
          if (out_ack) begin
            out_req <= 1'b0;
            state   <= st_withdraw;
          end
        end
        st_withdraw: begin
          // Next beat only after ack has fallen
          if (!out_ack) begin
            if (last_elem) begin
              batch_release <= 1'b1;
              busy          <= 1'b0;
              state         <= st_idle;
            end else begin
              state <= st_accumulate;
              if (loc_j == index_t'(`DNC_N - 1)) begin
                loc_j  <= '0;
                head_i <= head_i + 1'b1;
              end else begin
                loc_j <= loc_j + 1'b1;
              end
            end
          end
        end
        default: begin
          state <= st_idle;
        end
      endcase
    end
  end

  //////////////////////////////////////////////////
  // Output beat
  //////////////////////////////////////////////////

  // Captured once per element, held through the handshake
  always_ff @(posedge CLK) begin
    if (state == st_drain && mac_valid) begin
      out_beat <= '{head: head_i, loc: loc_j, value: mac_result};
    end
  end

  a_beat_stable: assert property (@(posedge CLK) disable iff (RST)
    (out_req && $past(out_req)) |-> $stable(out_beat))
    else $error("out_beat changed while out_req was high");

endmodule

/* source/dnc_mac_unit.sv */
// Unsigned Q1.15 MAC; result is floor of sum >> DNC_FRAC_W saturated to all ones, one cycle after last
`timescale 1ns/1ps
`include "dnc_defs.svh"

module dnc_mac_unit import dnc_pkg::*; (
  input  logic   CLK,
  input  logic   RST,
  input  fixed_t link_rd,
  input  fixed_t weight_rd,
  input  logic   mac_first,
  input  logic   mac_last,
  output fixed_t mac_result,
  output logic   mac_valid
);

  //////////////////////////////////////////////////
  // Multiply and accumulate
  //////////////////////////////////////////////////

  logic [2*`DNC_DATA_W-1:0]         product;
  acc_t                             acc;
  acc_t                             base;
  acc_t                             sum;
  logic                             in_sum;
  logic                             active;
  logic [`DNC_ACC_W-`DNC_FRAC_W-1:0] shifted;
  fixed_t                           sat_value;

  assign product = link_rd * weight_rd;
  assign active  = mac_first || in_sum;

  // First beat restarts the sum
  assign base = mac_first ? '0 : acc;
  assign sum  = base + acc_t'(product);

  // Floor shift, then clamp anything above 16 bits
  assign shifted   = sum[`DNC_ACC_W-1:`DNC_FRAC_W];
  assign sat_value = (|shifted[`DNC_ACC_W-`DNC_FRAC_W-1:`DNC_DATA_W]) ?
                     '1 : shifted[`DNC_DATA_W-1:0];

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      in_sum    <= 1'b0;
      mac_valid <= 1'b0;
    end else begin
      mac_valid <= active && mac_last;
      if (mac_last) begin
        in_sum <= 1'b0;
      end else if (mac_first) begin
        in_sum <= 1'b1;
      end
    end
  end

  // Accumulator and result, next sum may start right after last
  always_ff @(posedge CLK) begin
    if (active) begin
      acc <= sum;
    end
    if (active && mac_last) begin
      mac_result <= sat_value;
    end
  end

  // Running sum of unsigned products only ever grows
  a_acc_no_wrap: assert property (@(posedge CLK) disable iff (RST)
    (in_sum && !mac_first) |=> (acc >= $past(acc)))
    else $error("accumulator wrapped");

endmodule

/* source/dnc_operand_memory.sv */
// Link array is stored row-major (g, j); reads are registered and have one cycle of latency
`timescale 1ns/1ps
`include "dnc_defs.svh"

module dnc_operand_memory import dnc_pkg::*; (
  input  logic    CLK,
  input  logic    RST,
  input  mem_wr_t mem_wr,
  input  mem_rd_t mem_rd,
  output fixed_t  link_rd,
  output fixed_t  weight_rd
);

  localparam int LINK_DEPTH = `DNC_N * `DNC_N;
  localparam int WGT_DEPTH  = `DNC_R * `DNC_N;
  localparam int LINK_AW    = $clog2(LINK_DEPTH);
  localparam int WGT_AW     = $clog2(WGT_DEPTH);

  //////////////////////////////////////////////////
  // Storage
  //////////////////////////////////////////////////

  fixed_t link_mem [LINK_DEPTH];
  fixed_t wgt_mem  [WGT_DEPTH];

  logic [LINK_AW-1:0] link_waddr;
  logic [WGT_AW-1:0]  wgt_waddr;
  logic [LINK_AW-1:0] link_raddr;
  logic [WGT_AW-1:0]  wgt_raddr;

  // Loader addresses already start at zero per array
  assign link_waddr = mem_wr.addr[LINK_AW-1:0];
  assign wgt_waddr  = mem_wr.addr[WGT_AW-1:0];

  always_ff @(posedge CLK) begin
    if (mem_wr.en) begin
      if (mem_wr.sel_weight) begin
        wgt_mem[wgt_waddr] <= mem_wr.data;
      end else begin
        link_mem[link_waddr] <= mem_wr.data;
      end
    end
  end

  //////////////////////////////////////////////////
  // Read port
  //////////////////////////////////////////////////

  // L(g,j) walked along g for a fixed j, i.e. a column read
  // This is where the transpose happens, no copy pass needed
  assign link_raddr = {mem_rd.g, mem_rd.j};

  // w(i,g), head-major like the load order
  assign wgt_raddr = WGT_AW'({mem_rd.i, mem_rd.g});

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      link_rd   <= '0;
      weight_rd <= '0;
    end else begin
      link_rd   <= link_mem[link_raddr];
      weight_rd <= wgt_mem[wgt_raddr];
    end
  end

endmodule

/* source/dnc_operand_loader.sv */
// Words arrive link first (row-major), then weights; no words are taken while the batch is full
`timescale 1ns/1ps
`include "dnc_defs.svh"

module dnc_operand_loader import dnc_pkg::*; (
  input  logic       CLK,
  input  logic       RST,
  input  logic       in_req,
  input  fixed_t     in_word,
  output logic       in_ack,
  output mem_wr_t    mem_wr,
  output logic       batch_full,
  input  logic       batch_release
);

  // Word counts per batch
  localparam int LINK_WORDS  = `DNC_N * `DNC_N;
  localparam int TOTAL_WORDS = LINK_WORDS + `DNC_R * `DNC_N;

  //////////////////////////////////////////////////
  // Handshake and batch counter
  //////////////////////////////////////////////////

  load_addr_t cnt;
  logic       full;
  logic       accept;
  logic       wr_en;
  logic       wr_sel_weight;
  load_addr_t wr_addr;
  fixed_t     wr_data;

  // New word offered, previous one retired, room left
  assign accept = in_req && !in_ack && !full;

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      in_ack <= 1'b0;
      cnt    <= '0;
      full   <= 1'b0;
      wr_en  <= 1'b0;
    end else begin
      wr_en <= accept;
      // Ack rises with the write, falls one edge after req drops
      if (accept) begin
        in_ack <= 1'b1;
      end else if (!in_req) begin
        in_ack <= 1'b0;
      end
      if (accept) begin
        if (cnt == load_addr_t'(TOTAL_WORDS - 1)) begin
          cnt  <= '0;
          full <= 1'b1;
        end else begin
          cnt <= cnt + 1'b1;
        end
      end else if (batch_release) begin
        // Controller is done with the operands
        full <= 1'b0;
      end
    end
  end

  // Write payload, address is relative to the selected array
  always_ff @(posedge CLK) begin
    if (accept) begin
      wr_sel_weight <= (cnt >= load_addr_t'(LINK_WORDS));
      wr_addr       <= (cnt >= load_addr_t'(LINK_WORDS)) ?
                       cnt - load_addr_t'(LINK_WORDS) : cnt;
      wr_data       <= in_word;
    end
  end

  assign mem_wr = '{en: wr_en, sel_weight: wr_sel_weight, addr: wr_addr, data: wr_data};
  assign batch_full = full;

  //////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////

  // A word is never acknowledged out of a full batch
  a_no_ack_when_full: assert property (@(posedge CLK) disable iff (RST)
    $rose(in_ack) |-> !$past(batch_full))
    else $error("in_ack rose while batch_full was high");

endmodule

/* source/dnc_pkg.sv */
// Types only; all widths follow the macros in dnc_defs.svh
`include "dnc_defs.svh"

package dnc_pkg;

  // Operand and result word, unsigned Q1.15
  typedef logic [`DNC_DATA_W-1:0] fixed_t;
  typedef logic [`DNC_ACC_W-1:0]  acc_t;
  typedef logic [`DNC_IDX_W-1:0]  index_t;
  // Word position inside the selected array
  typedef logic [`DNC_CNT_W-1:0]  load_addr_t;

  // Loader write into the operand memory
  typedef struct packed {
    logic       en;
    logic       sel_weight;
    load_addr_t addr;
    fixed_t     data;
  } mem_wr_t;

  // Controller read, head i, location j, summation index g
  typedef struct packed {
    index_t i;
    index_t j;
    index_t g;
  } mem_rd_t;

  // One output beat, 20 bits with the default sizes
  typedef struct packed {
    index_t head;
    index_t loc;
    fixed_t value;
  } result_beat_t;

  // Controller FSM
  typedef enum logic [2:0] {
    st_idle,
    st_accumulate,
    st_drain,
    st_offer,
    st_withdraw
  } ctrl_state_t;

endpackage

/* source/dnc_defs.svh */
// Sizes are fixed at compile time; N must equal 2**DNC_IDX_W and R must not exceed N
`ifndef DNC_DEFS_SVH
`define DNC_DEFS_SVH

// Memory locations and read heads
`define DNC_N 4
`define DNC_R 2

// Q1.15 operands, unsigned
`define DNC_DATA_W 16
`define DNC_FRAC_W 15

// Room for N full-scale products without wrap
`define DNC_ACC_W 36

// Index of a head or location
`define DNC_IDX_W 2

// Load counter, covers N*N + R*N words
`define DNC_CNT_W 5

`endif
